// ==== hw/simd_pkg.sv ====
package simd_pkg;

	// machine sizes
	localparam int NUM_LANES     = 16;
	localparam int WORD_WIDTH    = 32;
	localparam int REG_COUNT     = 32;
	localparam int REG_SEL_WIDTH = 5;
	localparam int VECTOR_WIDTH  = NUM_LANES * WORD_WIDTH;	// 512

	// add, used for memory address offsets
	localparam logic [5:0] ALU_OP_ADD = 6'd5;

	// instruction field positions
	localparam int A_TYPE_MSB = 22;
	localparam int A_TYPE_LSB = 20;
	localparam int B_TYPE_MSB = 25;
	localparam int B_TYPE_LSB = 24;
	localparam int C_TYPE_MSB = 28;
	localparam int C_TYPE_LSB = 25;
	localparam int C_WB_BIT   = 29;	// load vs store

	// register fields, each REG_SEL_WIDTH wide
	localparam int REG_F0_LSB = 0;	// 4..0
	localparam int REG_F1_LSB = 5;	// 9..5, also dest
	localparam int REG_F2_LSB = 10;	// 14..10
	localparam int REG_F3_LSB = 15;	// 19..15

	typedef enum logic [2:0]
	{
		FMT_A,	// reg/reg
		FMT_B,	// immediate
		FMT_C,	// memory
		FMT_D,	// reserved
		FMT_E	// long immediate
	} instr_format_t;

	typedef enum logic [1:0]
	{
		OP2_SCALAR    = 2'd0,
		OP2_VECTOR    = 2'd1,
		OP2_IMMEDIATE = 2'd2
	} op2_src_t;

	// mask source, taken from the low NUM_LANES bits of a scalar read
	typedef enum logic [2:0]
	{
		MASK_S1     = 3'd0,
		MASK_NOT_S1 = 3'd1,
		MASK_S2     = 3'd2,
		MASK_NOT_S2 = 3'd3,
		MASK_NONE   = 3'd4	// all lanes on
	} mask_src_t;

endpackage

// ==== hw/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage import simd_pkg::*;
(
	input  logic                     clk,
	input  logic                     reset_i,
	input  logic                     flush_i,
	input  logic [31:0]              instruction_i,
	input  logic [31:0]              pc_i,
	input  logic [3:0]               lane_select_i,
	output logic [REG_SEL_WIDTH-1:0] scalar_sel1_o,
	output logic [REG_SEL_WIDTH-1:0] scalar_sel2_o,
	output logic [REG_SEL_WIDTH-1:0] vector_sel1_o,
	output logic [REG_SEL_WIDTH-1:0] vector_sel2_o,
	output logic [31:0]              instruction_o,
	output logic [31:0]              pc_o,
	output logic [WORD_WIDTH-1:0]    immediate_o,
	output logic                     op1_is_vector_o,
	output op2_src_t                 op2_src_o,
	output mask_src_t                mask_src_o,
	output logic                     store_value_is_vector_o,
	output logic                     has_writeback_o,
	output logic [REG_SEL_WIDTH-1:0] writeback_reg_o,
	output logic                     writeback_is_vector_o,
	output logic [5:0]               alu_op_o,
	output logic [3:0]               lane_select_o
);

	instr_format_t          fmt;
	logic [2:0]             a_type;
	logic [1:0]             b_type;
	logic [3:0]             c_type;
	logic                   c_scalar;	// C type 0..5
	logic [WORD_WIDTH-1:0]  immediate_nxt;
	logic                   op1_is_vector_nxt;
	op2_src_t               op2_src_nxt;
	mask_src_t              mask_src_nxt;
	logic [5:0]             alu_op_nxt;
	logic                   has_writeback_nxt;
	logic                   writeback_is_vector_nxt;

	assign a_type   = instruction_i[A_TYPE_MSB:A_TYPE_LSB];
	assign b_type   = instruction_i[B_TYPE_MSB:B_TYPE_LSB];
	assign c_type   = instruction_i[C_TYPE_MSB:C_TYPE_LSB];
	assign c_scalar = fmt == FMT_C && c_type <= 4'd5;

	// format from top bits; 1100 overlaps A and goes to D
	always_comb
	begin
		fmt = FMT_A;	// 1101, 1110
		if (!instruction_i[31])
			fmt = FMT_B;
		else if (!instruction_i[30])
			fmt = FMT_C;
		else if (instruction_i[31:28] == 4'b1100)
			fmt = FMT_D;
		else if (instruction_i[31:28] == 4'b1111)
			fmt = FMT_E;
	end

	// selects go straight out, the register files add the cycle
	always_comb
	begin
		if (fmt == FMT_A && a_type != 3'd0 && a_type <= 3'd3)
			scalar_sel1_o = instruction_i[REG_F2_LSB +: REG_SEL_WIDTH];	// s2 busy, mask via s1
		else
			scalar_sel1_o = instruction_i[REG_F0_LSB +: REG_SEL_WIDTH];

		if (c_scalar && !instruction_i[C_WB_BIT])
			scalar_sel2_o = instruction_i[REG_F1_LSB +: REG_SEL_WIDTH];	// scalar store value
		else if (fmt == FMT_A && !a_type[2])
			scalar_sel2_o = instruction_i[REG_F3_LSB +: REG_SEL_WIDTH];	// src2
		else
			scalar_sel2_o = instruction_i[REG_F2_LSB +: REG_SEL_WIDTH];	// mask

		vector_sel1_o = instruction_i[REG_F0_LSB +: REG_SEL_WIDTH];
		if (fmt == FMT_A && a_type[2] && a_type != 3'd7)
			vector_sel2_o = instruction_i[REG_F3_LSB +: REG_SEL_WIDTH];	// src2
		else
			vector_sel2_o = instruction_i[REG_F1_LSB +: REG_SEL_WIDTH];	// store value
	end

	// sign extended immediates
	always_comb
	begin
		case (fmt)
			FMT_B:        immediate_nxt = {{23{instruction_i[23]}}, instruction_i[23:15]};
			FMT_C, FMT_D: immediate_nxt = {{22{instruction_i[24]}}, instruction_i[24:15]};
			default:      immediate_nxt = {{11{instruction_i[25]}}, instruction_i[25:5]};
		endcase
	end

	always_comb
	begin
		case (fmt)
			FMT_A:   op1_is_vector_nxt = a_type != 3'd0;
			FMT_B:   op1_is_vector_nxt = b_type != 2'd0;
			FMT_C:   op1_is_vector_nxt = c_type >= 4'd12 && c_type <= 4'd14;	// scatter/gather
			default: op1_is_vector_nxt = 1'b0;
		endcase

		if (fmt == FMT_A)
			op2_src_nxt = instruction_i[22] ? OP2_VECTOR : OP2_SCALAR;
		else
			op2_src_nxt = OP2_IMMEDIATE;
	end

	// lane mask source per format
	always_comb
	begin
		mask_src_nxt = MASK_NONE;
		if (fmt == FMT_A)
		begin
			case (a_type)
				3'd2:    mask_src_nxt = MASK_S1;		// vector/scalar masked
				3'd3:    mask_src_nxt = MASK_NOT_S1;
				3'd5:    mask_src_nxt = MASK_S2;		// vector/vector masked
				3'd6:    mask_src_nxt = MASK_NOT_S2;
				3'd7:    mask_src_nxt = MASK_S1;		// reserved type
				default: mask_src_nxt = MASK_NONE;	// 0, 1, 4 unmasked
			endcase
		end
		else if (fmt == FMT_B)
		begin
			if (b_type == 2'd2)
				mask_src_nxt = MASK_NOT_S2;
		end
		else if (fmt == FMT_C)
		begin
			case (c_type)
				4'd7, 4'd10, 4'd13: mask_src_nxt = MASK_S2;	// block, strided, scatter
				4'd8, 4'd11, 4'd14: mask_src_nxt = MASK_NOT_S2;
				default:            mask_src_nxt = MASK_NONE;
			endcase
		end
	end

	always_comb
	begin
		case (fmt)
			FMT_A:   alu_op_nxt = instruction_i[28:23];
			FMT_B:   alu_op_nxt = {1'b0, instruction_i[30:26]};
			default: alu_op_nxt = ALU_OP_ADD;	// address offset
		endcase

		// all-zero word is a nop
		has_writeback_nxt = (fmt == FMT_A || fmt == FMT_B
			|| (fmt == FMT_C && instruction_i[C_WB_BIT])) && instruction_i != 32'd0;

		case (fmt)
			FMT_A:   writeback_is_vector_nxt = a_type != 3'd0;
			FMT_B:   writeback_is_vector_nxt = b_type != 2'd0;
			default: writeback_is_vector_nxt = c_type >= 4'd5;
		endcase
	end

	// decoded fields line up with register file read data
	always_ff @(posedge clk)
	begin
		if (reset_i || flush_i)
		begin
			instruction_o           <= '0;
			pc_o                    <= '0;
			immediate_o             <= '0;
			op1_is_vector_o         <= 1'b0;
			op2_src_o               <= OP2_SCALAR;
			mask_src_o              <= MASK_S1;	// encoding 0
			store_value_is_vector_o <= 1'b0;
			has_writeback_o         <= 1'b0;
			writeback_reg_o         <= '0;
			writeback_is_vector_o   <= 1'b0;
			alu_op_o                <= '0;
			lane_select_o           <= '0;
		end
		else
		begin
			instruction_o           <= instruction_i;
			pc_o                    <= pc_i;
			immediate_o             <= immediate_nxt;
			op1_is_vector_o         <= op1_is_vector_nxt;
			op2_src_o               <= op2_src_nxt;
			mask_src_o              <= mask_src_nxt;
			store_value_is_vector_o <= !c_scalar;
			has_writeback_o         <= has_writeback_nxt;
			writeback_reg_o         <= instruction_i[REG_F1_LSB +: REG_SEL_WIDTH];
			writeback_is_vector_o   <= writeback_is_vector_nxt;
			alu_op_o                <= alu_op_nxt;
			lane_select_o           <= lane_select_i;
		end
	end

endmodule

// ==== hw/scalar_reg_file.sv ====
`timescale 1ns/1ps

module scalar_reg_file import simd_pkg::*;
(
	input  logic                     clk,
	input  logic [REG_SEL_WIDTH-1:0] sel1_i,
	input  logic [REG_SEL_WIDTH-1:0] sel2_i,
	input  logic                     write_enable_i,
	input  logic [REG_SEL_WIDTH-1:0] write_reg_i,
	input  logic [WORD_WIDTH-1:0]    write_value_i,
	output logic [WORD_WIDTH-1:0]    value1_o,
	output logic [WORD_WIDTH-1:0]    value2_o
);

	logic [WORD_WIDTH-1:0] regs [REG_COUNT];

	always_ff @(posedge clk)
	begin
		if (write_enable_i)
			regs[write_reg_i] <= write_value_i;
	end

	// registered read, one cycle behind the select
	// same-cycle write is not visible yet
	always_ff @(posedge clk)
	begin
		value1_o <= regs[sel1_i];
		value2_o <= regs[sel2_i];
	end

endmodule

// ==== hw/vector_reg_file.sv ====
`timescale 1ns/1ps

module vector_reg_file import simd_pkg::*;
(
	input  logic                     clk,
	input  logic [REG_SEL_WIDTH-1:0] sel1_i,
	input  logic [REG_SEL_WIDTH-1:0] sel2_i,
	input  logic                     write_enable_i,
	input  logic [REG_SEL_WIDTH-1:0] write_reg_i,
	input  logic [NUM_LANES-1:0]     write_mask_i,
	input  logic [VECTOR_WIDTH-1:0]  write_value_i,
	output logic [VECTOR_WIDTH-1:0]  value1_o,
	output logic [VECTOR_WIDTH-1:0]  value2_o
);

	// lane n sits at bits n*WORD_WIDTH and up
	logic [VECTOR_WIDTH-1:0] regs [REG_COUNT];

	// masked write, untouched lanes keep their value
	always_ff @(posedge clk)
	begin
		for (int lane = 0; lane < NUM_LANES; lane++)
		begin
			if (write_enable_i && write_mask_i[lane])
				regs[write_reg_i][lane*WORD_WIDTH +: WORD_WIDTH]
					<= write_value_i[lane*WORD_WIDTH +: WORD_WIDTH];
		end
	end

	always_ff @(posedge clk)
	begin
		value1_o <= regs[sel1_i];	// old data on a same-cycle write
		value2_o <= regs[sel2_i];
	end

endmodule

// ==== hw/operand_select.sv ====
`timescale 1ns/1ps

module operand_select import simd_pkg::*;
(
	input  logic                    op1_is_vector_i,
	input  op2_src_t                op2_src_i,
	input  mask_src_t               mask_src_i,
	input  logic                    store_value_is_vector_i,
	input  logic [WORD_WIDTH-1:0]   immediate_i,
	input  logic [WORD_WIDTH-1:0]   scalar1_i,
	input  logic [WORD_WIDTH-1:0]   scalar2_i,
	input  logic [VECTOR_WIDTH-1:0] vector1_i,
	input  logic [VECTOR_WIDTH-1:0] vector2_i,
	output logic [VECTOR_WIDTH-1:0] operand1_o,
	output logic [VECTOR_WIDTH-1:0] operand2_o,
	output logic [NUM_LANES-1:0]    mask_o,
	output logic [VECTOR_WIDTH-1:0] store_value_o
);

	logic [VECTOR_WIDTH-1:0] scalar1_bcast;
	logic [VECTOR_WIDTH-1:0] scalar2_bcast;
	logic [VECTOR_WIDTH-1:0] imm_bcast;

	// scalars copied into every lane
	assign scalar1_bcast = {NUM_LANES{scalar1_i}};
	assign scalar2_bcast = {NUM_LANES{scalar2_i}};
	assign imm_bcast     = {NUM_LANES{immediate_i}};

	always_comb
	begin
		operand1_o = op1_is_vector_i ? vector1_i : scalar1_bcast;

		case (op2_src_i)
			OP2_SCALAR: operand2_o = scalar2_bcast;
			OP2_VECTOR: operand2_o = vector2_i;
			default:    operand2_o = imm_bcast;	// immediate
		endcase

		// one mask bit per lane from the scalar low bits
		case (mask_src_i)
			MASK_S1:     mask_o = scalar1_i[NUM_LANES-1:0];
			MASK_NOT_S1: mask_o = ~scalar1_i[NUM_LANES-1:0];
			MASK_S2:     mask_o = scalar2_i[NUM_LANES-1:0];
			MASK_NOT_S2: mask_o = ~scalar2_i[NUM_LANES-1:0];
			default:     mask_o = '1;	// no mask
		endcase

		store_value_o = store_value_is_vector_i ? vector2_i : scalar2_bcast;
	end

endmodule

// ==== hw/simd_decode_top.sv ====
`timescale 1ns/1ps

module simd_decode_top import simd_pkg::*;
(
	input  logic                     clk,
	input  logic                     reset_i,
	input  logic                     flush_i,
	input  logic [31:0]              instruction_i,
	input  logic [31:0]              pc_i,
	input  logic [3:0]               lane_select_i,
	input  logic                     wb_enable_i,
	input  logic                     wb_is_vector_i,
	input  logic [REG_SEL_WIDTH-1:0] wb_reg_i,
	input  logic [NUM_LANES-1:0]     wb_lane_mask_i,
	input  logic [VECTOR_WIDTH-1:0]  wb_value_i,	// scalar write uses lane 0
	output logic [31:0]              instruction_o,
	output logic [31:0]              pc_o,
	output logic [WORD_WIDTH-1:0]    immediate_o,
	output logic [5:0]               alu_op_o,
	output logic [3:0]               lane_select_o,
	output logic                     has_writeback_o,
	output logic [REG_SEL_WIDTH-1:0] writeback_reg_o,
	output logic                     writeback_is_vector_o,
	output logic [VECTOR_WIDTH-1:0]  operand1_o,
	output logic [VECTOR_WIDTH-1:0]  operand2_o,
	output logic [NUM_LANES-1:0]     mask_o,
	output logic [VECTOR_WIDTH-1:0]  store_value_o
);

	logic [REG_SEL_WIDTH-1:0] scalar_sel1;
	logic [REG_SEL_WIDTH-1:0] scalar_sel2;
	logic [REG_SEL_WIDTH-1:0] vector_sel1;
	logic [REG_SEL_WIDTH-1:0] vector_sel2;
	logic                     op1_is_vector;
	op2_src_t                 op2_src;
	mask_src_t                mask_src;
	logic                     store_value_is_vector;
	logic [WORD_WIDTH-1:0]    scalar1;
	logic [WORD_WIDTH-1:0]    scalar2;
	logic [VECTOR_WIDTH-1:0]  vector1;
	logic [VECTOR_WIDTH-1:0]  vector2;

	decode_stage decode0
	(
		.clk                     (clk),
		.reset_i                 (reset_i),
		.flush_i                 (flush_i),
		.instruction_i           (instruction_i),
		.pc_i                    (pc_i),
		.lane_select_i           (lane_select_i),
		.scalar_sel1_o           (scalar_sel1),
		.scalar_sel2_o           (scalar_sel2),
		.vector_sel1_o           (vector_sel1),
		.vector_sel2_o           (vector_sel2),
		.instruction_o           (instruction_o),
		.pc_o                    (pc_o),
		.immediate_o             (immediate_o),
		.op1_is_vector_o         (op1_is_vector),
		.op2_src_o               (op2_src),
		.mask_src_o              (mask_src),
		.store_value_is_vector_o (store_value_is_vector),
		.has_writeback_o         (has_writeback_o),
		.writeback_reg_o         (writeback_reg_o),
		.writeback_is_vector_o   (writeback_is_vector_o),
		.alu_op_o                (alu_op_o),
		.lane_select_o           (lane_select_o)
	);

	// write port steered by wb_is_vector_i
	scalar_reg_file srf0
	(
		.clk            (clk),
		.sel1_i         (scalar_sel1),
		.sel2_i         (scalar_sel2),
		.write_enable_i (wb_enable_i && !wb_is_vector_i),
		.write_reg_i    (wb_reg_i),
		.write_value_i  (wb_value_i[WORD_WIDTH-1:0]),
		.value1_o       (scalar1),
		.value2_o       (scalar2)
	);

	vector_reg_file vrf0
	(
		.clk            (clk),
		.sel1_i         (vector_sel1),
		.sel2_i         (vector_sel2),
		.write_enable_i (wb_enable_i && wb_is_vector_i),
		.write_reg_i    (wb_reg_i),
		.write_mask_i   (wb_lane_mask_i),
		.write_value_i  (wb_value_i),
		.value1_o       (vector1),
		.value2_o       (vector2)
	);

	operand_select opsel0
	(
		.op1_is_vector_i         (op1_is_vector),
		.op2_src_i               (op2_src),
		.mask_src_i              (mask_src),
		.store_value_is_vector_i (store_value_is_vector),
		.immediate_i             (immediate_o),
		.scalar1_i               (scalar1),
		.scalar2_i               (scalar2),
		.vector1_i               (vector1),
		.vector2_i               (vector2),
		.operand1_o              (operand1_o),
		.operand2_o              (operand2_o),
		.mask_o                  (mask_o),
		.store_value_o           (store_value_o)
	);

endmodule

// ==== sim/simd_decode_tb.sv ====
`timescale 1ns/1ps

module simd_decode_tb import simd_pkg::*;;

	logic                     clk = 1'b0;
	logic                     reset_i;
	logic                     flush_i;
	logic [31:0]              instruction_i;
	logic [31:0]              pc_i;
	logic [3:0]               lane_select_i;
	logic                     wb_enable_i;
	logic                     wb_is_vector_i;
	logic [REG_SEL_WIDTH-1:0] wb_reg_i;
	logic [NUM_LANES-1:0]     wb_lane_mask_i;
	logic [VECTOR_WIDTH-1:0]  wb_value_i;
	logic [31:0]              instruction_o;
	logic [31:0]              pc_o;
	logic [WORD_WIDTH-1:0]    immediate_o;
	logic [5:0]               alu_op_o;
	logic [3:0]               lane_select_o;
	logic                     has_writeback_o;
	logic [REG_SEL_WIDTH-1:0] writeback_reg_o;
	logic                     writeback_is_vector_o;
	logic [VECTOR_WIDTH-1:0]  operand1_o;
	logic [VECTOR_WIDTH-1:0]  operand2_o;
	logic [NUM_LANES-1:0]     mask_o;
	logic [VECTOR_WIDTH-1:0]  store_value_o;

	// register file mirrors
	logic [WORD_WIDTH-1:0]   sregs [REG_COUNT];
	logic [VECTOR_WIDTH-1:0] vregs [REG_COUNT];

	// expected results, one instruction deep
	logic                     pending;
	logic [31:0]              exp_instr;
	logic [31:0]              exp_pc;
	logic [WORD_WIDTH-1:0]    exp_imm;
	logic [5:0]               exp_alu;
	logic [3:0]               exp_lane;
	logic                     exp_hasw;
	logic [REG_SEL_WIDTH-1:0] exp_wbreg;
	logic                     exp_wbvec;
	logic [REG_SEL_WIDTH-1:0] exp_ssel1;
	logic [REG_SEL_WIDTH-1:0] exp_ssel2;
	logic [REG_SEL_WIDTH-1:0] exp_vsel1;
	logic [REG_SEL_WIDTH-1:0] exp_vsel2;
	logic [VECTOR_WIDTH-1:0]  exp_op1;
	logic [VECTOR_WIDTH-1:0]  exp_op2;
	logic [NUM_LANES-1:0]     exp_mask;
	logic [VECTOR_WIDTH-1:0]  exp_store;
	int                       error_count = 0;

	simd_decode_top dut0
	(
		.clk                   (clk),
		.reset_i               (reset_i),
		.flush_i               (flush_i),
		.instruction_i         (instruction_i),
		.pc_i                  (pc_i),
		.lane_select_i         (lane_select_i),
		.wb_enable_i           (wb_enable_i),
		.wb_is_vector_i        (wb_is_vector_i),
		.wb_reg_i              (wb_reg_i),
		.wb_lane_mask_i        (wb_lane_mask_i),
		.wb_value_i            (wb_value_i),
		.instruction_o         (instruction_o),
		.pc_o                  (pc_o),
		.immediate_o           (immediate_o),
		.alu_op_o              (alu_op_o),
		.lane_select_o         (lane_select_o),
		.has_writeback_o       (has_writeback_o),
		.writeback_reg_o       (writeback_reg_o),
		.writeback_is_vector_o (writeback_is_vector_o),
		.operand1_o            (operand1_o),
		.operand2_o            (operand2_o),
		.mask_o                (mask_o),
		.store_value_o         (store_value_o)
	);

	always #10 clk = ~clk;	// 20 ns period

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_field(input string name, input logic [WORD_WIDTH-1:0] got,
		input logic [WORD_WIDTH-1:0] exp);
		if (got !== exp)
		begin
			error_count++;
			abort_run($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
				$time, name, got, exp));
		end
	endtask

	task automatic check_vector(input string name, input logic [VECTOR_WIDTH-1:0] got,
		input logic [VECTOR_WIDTH-1:0] exp);
		if (got !== exp)
		begin
			error_count++;
			abort_run($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
				$time, name, got, exp));
		end
	endtask

	task automatic check_mask(input string name, input logic [NUM_LANES-1:0] got,
		input logic [NUM_LANES-1:0] exp);
		if (got !== exp)
		begin
			error_count++;
			abort_run($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
				$time, name, got, exp));
		end
	endtask

	// random word of a given format, other bits free
	function automatic logic [31:0] make_instr(input instr_format_t f);
		logic [31:0] r;
		logic [31:0] pick;
		r = $urandom;
		pick = $urandom;
		case (f)
			FMT_A:   r[31:28] = pick[0] ? 4'b1101 : 4'b1110;
			FMT_B:   r[31] = 1'b0;
			FMT_C:   r[31:30] = 2'b10;
			FMT_E:   r[31:28] = 4'b1111;
			default: r[31:28] = 4'b1100;
		endcase
		return r;
	endfunction

	// reference decode plus operand forming from the mirrors
	task automatic predict(input logic [31:0] ins, input logic [31:0] pc,
		input logic [3:0] lane, input logic fl);
		instr_format_t         fmt;
		logic [2:0]            at;
		logic [1:0]            bt;
		logic [3:0]            ct;
		logic                  c_scalar;
		logic                  op1v;
		logic                  storev;
		op2_src_t              o2;
		mask_src_t             ms;
		logic [WORD_WIDTH-1:0] s1;
		logic [WORD_WIDTH-1:0] s2;
		at = ins[22:20];
		bt = ins[25:24];
		ct = ins[28:25];
		if (!ins[31])
			fmt = FMT_B;
		else if (!ins[30])
			fmt = FMT_C;
		else if (ins[31:28] == 4'b1100)
			fmt = FMT_D;	// overlaps A, D wins
		else if (ins[31:28] == 4'b1111)
			fmt = FMT_E;
		else
			fmt = FMT_A;
		c_scalar = fmt == FMT_C && ct <= 4'd5;

		// read selects
		exp_ssel1 = (fmt == FMT_A && at >= 3'd1 && at <= 3'd3) ? ins[14:10] : ins[4:0];
		if (c_scalar && !ins[29])
			exp_ssel2 = ins[9:5];
		else if (fmt == FMT_A && at <= 3'd3)
			exp_ssel2 = ins[19:15];
		else
			exp_ssel2 = ins[14:10];
		exp_vsel1 = ins[4:0];
		exp_vsel2 = (fmt == FMT_A && at >= 3'd4 && at <= 3'd6) ? ins[19:15] : ins[9:5];

		case (fmt)
			FMT_B:        exp_imm = {{23{ins[23]}}, ins[23:15]};
			FMT_C, FMT_D: exp_imm = {{22{ins[24]}}, ins[24:15]};
			default:      exp_imm = {{11{ins[25]}}, ins[25:5]};
		endcase
		op1v = (fmt == FMT_A && at != 3'd0) || (fmt == FMT_B && bt != 2'd0)
			|| (fmt == FMT_C && ct >= 4'd12 && ct <= 4'd14);
		o2 = fmt != FMT_A ? OP2_IMMEDIATE : (ins[22] ? OP2_VECTOR : OP2_SCALAR);

		// mask tables
		ms = MASK_NONE;
		if (fmt == FMT_A)
		begin
			case (at)
				3'd2, 3'd7: ms = MASK_S1;
				3'd3:       ms = MASK_NOT_S1;
				3'd5:       ms = MASK_S2;
				3'd6:       ms = MASK_NOT_S2;
				default:    ms = MASK_NONE;
			endcase
		end
		else if (fmt == FMT_B && bt == 2'd2)
			ms = MASK_NOT_S2;
		else if (fmt == FMT_C)
		begin
			case (ct)
				4'd7, 4'd10, 4'd13: ms = MASK_S2;
				4'd8, 4'd11, 4'd14: ms = MASK_NOT_S2;
				default:            ms = MASK_NONE;
			endcase
		end
		storev = !c_scalar;

		case (fmt)
			FMT_A:   exp_alu = ins[28:23];
			FMT_B:   exp_alu = {1'b0, ins[30:26]};
			default: exp_alu = ALU_OP_ADD;
		endcase
		exp_hasw = (fmt == FMT_A || fmt == FMT_B || (fmt == FMT_C && ins[29])) && ins != 32'd0;
		case (fmt)
			FMT_A:   exp_wbvec = at != 3'd0;
			FMT_B:   exp_wbvec = bt != 2'd0;
			default: exp_wbvec = ct >= 4'd5;
		endcase
		exp_instr = ins;
		exp_pc = pc;
		exp_lane = lane;
		exp_wbreg = ins[9:5];

		// flushed slot, fields cleared but the selects still read
		if (fl)
		begin
			exp_instr = '0;
			exp_pc = '0;
			exp_lane = '0;
			exp_imm = '0;
			exp_alu = '0;
			exp_hasw = 1'b0;
			exp_wbreg = '0;
			exp_wbvec = 1'b0;
			op1v = 1'b0;
			storev = 1'b0;
			o2 = OP2_SCALAR;
			ms = MASK_S1;
		end

		s1 = sregs[exp_ssel1];
		s2 = sregs[exp_ssel2];
		exp_op1 = op1v ? vregs[exp_vsel1] : {NUM_LANES{s1}};	// broadcast
		case (o2)
			OP2_SCALAR: exp_op2 = {NUM_LANES{s2}};
			OP2_VECTOR: exp_op2 = vregs[exp_vsel2];
			default:    exp_op2 = {NUM_LANES{exp_imm}};
		endcase
		case (ms)
			MASK_S1:     exp_mask = s1[NUM_LANES-1:0];
			MASK_NOT_S1: exp_mask = ~s1[NUM_LANES-1:0];
			MASK_S2:     exp_mask = s2[NUM_LANES-1:0];
			MASK_NOT_S2: exp_mask = ~s2[NUM_LANES-1:0];
			default:     exp_mask = '1;
		endcase
		exp_store = storev ? vregs[exp_vsel2] : {NUM_LANES{s2}};
	endtask

	task automatic check_outputs();
		check_field("instruction_o", instruction_o, exp_instr);
		check_field("pc_o", pc_o, exp_pc);
		check_field("immediate_o", immediate_o, exp_imm);
		check_field("alu_op_o", 32'(alu_op_o), 32'(exp_alu));
		check_field("lane_select_o", 32'(lane_select_o), 32'(exp_lane));
		check_field("has_writeback_o", 32'(has_writeback_o), 32'(exp_hasw));
		check_field("writeback_reg_o", 32'(writeback_reg_o), 32'(exp_wbreg));
		check_field("writeback_is_vector_o", 32'(writeback_is_vector_o), 32'(exp_wbvec));
		check_vector("operand1_o", operand1_o, exp_op1);
		check_vector("operand2_o", operand2_o, exp_op2);
		check_mask("mask_o", mask_o, exp_mask);
		check_vector("store_value_o", store_value_o, exp_store);
	endtask

	// drive the write port and update the mirror, lands at the next edge
	task automatic drive_write(input logic vec, input logic [REG_SEL_WIDTH-1:0] r,
		input logic [NUM_LANES-1:0] lanes);
		wb_enable_i = 1'b1;
		wb_is_vector_i = vec;
		wb_reg_i = r;
		wb_lane_mask_i = lanes;
		for (int l = 0; l < NUM_LANES; l++)
			wb_value_i[l*WORD_WIDTH +: WORD_WIDTH] = $urandom;
		if (vec)
		begin
			for (int l = 0; l < NUM_LANES; l++)
			begin
				if (lanes[l])
					vregs[r][l*WORD_WIDTH +: WORD_WIDTH] = wb_value_i[l*WORD_WIDTH +: WORD_WIDTH];
			end
		end
		else
			sregs[r] = wb_value_i[WORD_WIDTH-1:0];	// lane 0 only
	endtask

	// one clock: check the last result, then present the next instruction
	task automatic step(input logic [31:0] ins, input logic fl, input logic do_wb);
		logic [31:0]              rnd;
		logic [REG_SEL_WIDTH-1:0] wreg;
		logic                     vec;
		@(posedge clk);
		#1;
		if (pending)
			check_outputs();
		rnd = $urandom;
		instruction_i = ins;
		pc_i = $urandom;
		lane_select_i = rnd[3:0];
		flush_i = fl;
		predict(ins, pc_i, rnd[3:0], fl);	// mirrors still hold pre-write data
		pending = 1'b1;
		wreg = rnd[8:4];
		vec = rnd[9];
		// keep writes off registers read this cycle
		if (vec)
			wb_enable_i = do_wb && wreg != exp_vsel1 && wreg != exp_vsel2;
		else
			wb_enable_i = do_wb && wreg != exp_ssel1 && wreg != exp_ssel2;
		if (wb_enable_i)
			drive_write(vec, wreg, rnd[31:16]);
	endtask

	initial
	begin
		logic [31:0] ins;
		logic [31:0] rnd;
		logic        fl;
		logic        fl_prev;
		int          n;
		instr_format_t fsel;
		void'($urandom(32'hef56_000f));
		reset_i = 1'b1;
		flush_i = 1'b0;
		instruction_i = make_instr(FMT_A);	// live word with a writeback under reset
		pc_i = $urandom | 32'd1;
		lane_select_i = '0;
		wb_enable_i = 1'b0;
		wb_is_vector_i = 1'b0;
		wb_reg_i = '0;
		wb_lane_mask_i = '0;
		wb_value_i = '0;
		pending = 1'b0;

		for (n = 0; n < 4; n++)
			@(posedge clk);
		#1;
		reset_i = 1'b0;
		check_field("instruction_o after reset", instruction_o, 32'd0);
		check_field("pc_o after reset", pc_o, 32'd0);
		check_field("has_writeback_o after reset", 32'(has_writeback_o), 32'd0);

		// fill both files, then random masked vector writes
		for (int r = 0; r < REG_COUNT; r++)
		begin
			@(posedge clk);
			#1;
			drive_write(1'b0, r[4:0], '1);
			@(posedge clk);
			#1;
			drive_write(1'b1, r[4:0], '1);
		end
		for (int r = 0; r < REG_COUNT; r++)
		begin
			@(posedge clk);
			#1;
			rnd = $urandom;
			drive_write(1'b1, r[4:0], rnd[15:0]);
		end

		// format A, every type back to back
		for (int i = 0; i < 64; i++)
		begin
			ins = make_instr(FMT_A);
			ins[22:20] = i[2:0];
			step(ins, 1'b0, 1'b0);
		end

		// immediates of B, C and E
		for (int i = 0; i < 60; i++)
		begin
			fsel = (i % 3 == 0) ? FMT_B : ((i % 3 == 1) ? FMT_C : FMT_E);
			step(make_instr(fsel), 1'b0, 1'b0);
		end

		// memory accesses, all C types with and without writeback
		for (int i = 0; i < 64; i++)
		begin
			ins = make_instr(FMT_C);
			ins[28:25] = i[3:0];
			ins[29] = i[4];
			step(ins, 1'b0, 1'b0);
		end
		step(32'd0, 1'b0, 1'b0);	// all-zero word, no writeback

		// single-cycle flushes
		fl_prev = 1'b0;
		for (int i = 0; i < 48; i++)
		begin
			rnd = $urandom;
			fl = !fl_prev && rnd[1:0] == 2'd0;
			step($urandom, fl, 1'b0);
			fl_prev = fl;
		end

		// random stream with writes mixed in
		for (int i = 0; i < 200; i++)
			step($urandom, 1'b0, 1'b1);
		step(32'd0, 1'b0, 1'b0);	// drains the last check

		if (error_count == 0)
		begin
			$display("PASS: all tests");
			$finish;
		end
		else
			abort_run("errors were found during the run");
	end

endmodule

// ==== compile.f ====
hw/simd_pkg.sv
hw/decode_stage.sv
hw/scalar_reg_file.sv
hw/vector_reg_file.sv
hw/operand_select.sv
hw/simd_decode_top.sv
sim/simd_decode_tb.sv

// ==== Makefile ====
# verilator build of the simd decode testbench

SIM = obj_dir/Vsimd_decode_tb

all: run

compile:
	verilator --binary --timing --top-module simd_decode_tb -f compile.f

# the log decides pass or fail, not the simulator exit code
run: compile
	./$(SIM) > run.log 2>&1 || true
	cat run.log
	grep -q "^PASS: all tests$$" run.log

clean:
	rm -rf obj_dir run.log

.PHONY: all compile run clean
